// ==== logic/uart_pkg.sv ====
//##################################################
// uart_pkg
// shared widths, register map, frame states and
// the bus and configuration structs of the UART
//##################################################

`default_nettype none

package uart_pkg;

    localparam int FIFO_ADDR_W = 4;     // 16 entries, 15 usable
    localparam int DATA_W      = 8;
    localparam int SHIFT_W     = 11;    // start + data + parity/stop + stop
    localparam int BUS_W       = 32;
    localparam int REG_ADDR_W  = 3;

    // word index on the register bus
    typedef enum logic [REG_ADDR_W-1:0] {
        REG_TXDATA = 3'd0,
        REG_RXDATA = 3'd1,
        REG_TXCTRL = 3'd2,
        REG_RXCTRL = 3'd3,
        REG_STATUS = 3'd4,  // rx error flags, read only
        REG_SCALER = 3'd6
    } uart_reg_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_PARITY,
        ST_STOP
    } uart_frame_state_e;

    typedef struct packed {
        logic ena;
        logic nstop;    // second stop bit
        logic par;      // even parity bit enable
    } uart_dir_cfg_t;

    typedef struct packed {
        logic             valid;
        logic             write;
        uart_reg_e        addr;
        logic [BUS_W-1:0] wdata;
    } uart_req_t;

    typedef struct packed {
        logic             valid;
        logic [BUS_W-1:0] rdata;
    } uart_resp_t;

    typedef struct packed {
        logic parity;
        logic stopbit;
    } uart_rx_err_t;

endpackage

`default_nettype wire

// ==== logic/uart_baud_gen.sv ====
//##################################################
// uart_baud_gen
// divides the clock by the scaler into a bit-clock
// level, strobes on its rising and falling edges
//##################################################

`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen import uart_pkg::*; (
    input  wire logic        i_clk,
    input  wire logic        i_nrst,
    input  wire logic [30:0] i_scaler,
    input  wire logic        i_rd,
    input  wire logic        i_tx_busy,
    input  wire logic        i_rx_busy,
    output logic             o_tx_tick,
    output logic             o_rx_tick
);

    logic [30:0] cnt;
    logic [30:0] scaler_q;
    logic        level;
    logic        wrap;
    logic        idle_line;

    // no wrap in the cycle the scaler gets a new value
    assign wrap = (i_scaler != '0) && (i_scaler == scaler_q)
                  && (cnt == i_scaler - 31'd1);

    assign o_tx_tick = wrap & ~level;   // level about to rise
    assign o_rx_tick = wrap & level;    // level about to fall

    // nothing in flight, so phase can follow the next start edge
    assign idle_line = ~i_rx_busy & i_rd & ~i_tx_busy;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt      <= '0;
            scaler_q <= '0;
            level    <= 1'b1;
        end else begin
            scaler_q <= i_scaler;
            if (i_scaler != scaler_q) begin
                cnt <= '0;
            end else if (i_scaler != '0) begin
                if (idle_line) begin
                    cnt   <= '0;
                    level <= 1'b1;
                end else if (wrap) begin
                    cnt   <= '0;
                    level <= ~level;
                end else begin
                    cnt <= cnt + 31'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/uart_fifo.sv ====
//##################################################
// uart_fifo
// 16-entry byte FIFO, head visible without a pop
// pushes when full and pops when empty are dropped
//##################################################

`timescale 1ns/1ps
`default_nettype none

module uart_fifo import uart_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_nrst,
    input  wire logic              i_push,
    input  wire logic [DATA_W-1:0] i_wdata,
    input  wire logic              i_pop,
    output logic      [DATA_W-1:0] o_rdata,
    output logic                   o_full,
    output logic                   o_empty
);

    logic [DATA_W-1:0]      mem [0:(1 << FIFO_ADDR_W)-1];
    logic [FIFO_ADDR_W-1:0] wr_ptr;
    logic [FIFO_ADDR_W-1:0] rd_ptr;
    logic [FIFO_ADDR_W-1:0] wr_ptr_nxt;
    logic                   do_push;
    logic                   do_pop;

    assign wr_ptr_nxt = wr_ptr + 1'b1;

    // one slot stays free to tell full from empty
    assign o_full  = (wr_ptr_nxt == rd_ptr);
    assign o_empty = (wr_ptr == rd_ptr);
    assign o_rdata = mem[rd_ptr];

    assign do_push = i_push & ~o_full;
    assign do_pop  = i_pop & ~o_empty;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr_nxt;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
//##################################################
// uart_tx
// transmit frame FSM, shifts start, 8 data bits,
// optional even parity and 1 or 2 stop bits
//##################################################

`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_nrst,
    input  wire logic              i_tick,
    input  wire uart_dir_cfg_t     i_cfg,
    input  wire logic              i_empty,
    input  wire logic [DATA_W-1:0] i_data,
    output logic                   o_pop,
    output logic                   o_td,
    output logic                   o_busy
);

    uart_frame_state_e  state;
    logic [SHIFT_W-1:0] shift;
    logic [3:0]         frame_cnt;
    logic               stop_cnt;
    logic               start;

    assign start  = i_tick && (state == ST_IDLE) && !i_empty && i_cfg.ena;
    assign o_pop  = start;
    assign o_td   = shift[0];
    assign o_busy = (state != ST_IDLE) || !i_empty;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state     <= ST_IDLE;
            shift     <= '1;    // line idles high
            frame_cnt <= '0;
            stop_cnt  <= 1'b0;
        end else if (i_tick) begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        if (i_cfg.par) begin
                            shift <= {1'b1, ^i_data, i_data, 1'b0};
                        end else begin
                            shift <= {2'b11, i_data, 1'b0};
                        end
                        state     <= ST_START;
                        frame_cnt <= '0;
                    end else begin
                        shift <= '1;
                    end
                end
                ST_START: state <= ST_DATA;
                ST_DATA: begin
                    if (frame_cnt == 4'd8) begin    // last data bit on the line
                        state    <= i_cfg.par ? ST_PARITY : ST_STOP;
                        stop_cnt <= i_cfg.nstop;
                    end
                end
                ST_PARITY: begin
                    state    <= ST_STOP;
                    stop_cnt <= i_cfg.nstop;
                end
                ST_STOP: begin
                    if (!stop_cnt) begin
                        state <= ST_IDLE;
                    end
                    stop_cnt <= 1'b0;
                end
                default: state <= ST_IDLE;
            endcase

            if (state != ST_IDLE) begin
                frame_cnt <= frame_cnt + 4'd1;
                shift     <= {1'b1, shift[SHIFT_W-1:1]};
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
//##################################################
// uart_rx
// receive frame FSM, samples at the bit centre,
// checks parity and stop bits, pushes the byte
//##################################################

`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  wire logic          i_clk,
    input  wire logic          i_nrst,
    input  wire logic          i_tick,
    input  wire uart_dir_cfg_t i_cfg,
    input  wire logic          i_rd,
    output logic               o_push,
    output logic [DATA_W-1:0]  o_data,
    output uart_rx_err_t       o_err,
    output logic               o_busy
);

    uart_frame_state_e state;
    logic [DATA_W-1:0] shift;
    logic [2:0]        bit_cnt;
    logic              stop_cnt;
    logic              stop_low;    // first of two stop bits was low

    assign o_data = shift;
    assign o_busy = (state != ST_IDLE);
    assign o_push = i_tick && (state == ST_STOP) && !stop_cnt;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state    <= ST_IDLE;
            shift    <= '0;
            bit_cnt  <= '0;
            stop_cnt <= 1'b0;
            stop_low <= 1'b0;
            o_err    <= '0;
        end else if (i_tick) begin
            case (state)
                ST_IDLE: begin
                    // this tick is the middle of the start bit
                    if (!i_rd && i_cfg.ena) begin
                        state   <= ST_DATA;
                        shift   <= '0;
                        bit_cnt <= '0;
                    end
                end
                ST_DATA: begin
                    shift <= {i_rd, shift[DATA_W-1:1]};    // lsb first
                    if (bit_cnt == 3'd7) begin
                        state    <= i_cfg.par ? ST_PARITY : ST_STOP;
                        stop_cnt <= i_cfg.nstop;
                        stop_low <= 1'b0;
                    end else begin
                        bit_cnt <= bit_cnt + 3'd1;
                    end
                end
                ST_PARITY: begin
                    o_err.parity <= (^shift) ^ i_rd;   // even parity
                    state        <= ST_STOP;
                    stop_cnt     <= i_cfg.nstop;
                    stop_low     <= 1'b0;
                end
                ST_STOP: begin
                    if (stop_cnt) begin
                        stop_low <= ~i_rd;
                        stop_cnt <= 1'b0;
                    end else begin
                        o_err.stopbit <= ~i_rd | stop_low;
                        state         <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/uart_regs.sv ====
//##################################################
// uart_regs
// register decode for the UART, control and scaler
// registers, FIFO strobes, one-cycle read response
//##################################################

`timescale 1ns/1ps
`default_nettype none

module uart_regs import uart_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_nrst,
    input  wire uart_req_t         i_req,
    input  wire logic              i_tx_full,
    input  wire logic              i_rx_empty,
    input  wire logic [DATA_W-1:0] i_rx_data,
    input  wire uart_rx_err_t      i_rx_err,
    output uart_resp_t             o_resp,
    output uart_dir_cfg_t          o_tx_cfg,
    output uart_dir_cfg_t          o_rx_cfg,
    output logic [30:0]            o_scaler,
    output logic                   o_tx_push,
    output logic [DATA_W-1:0]      o_tx_wdata,
    output logic                   o_rx_pop
);

    logic [BUS_W-1:0] rdata;
    logic             wr_en;
    logic             rd_en;

    assign wr_en      = i_req.valid & i_req.write;
    assign rd_en      = i_req.valid & ~i_req.write;
    assign o_tx_wdata = i_req.wdata[DATA_W-1:0];

    always_comb begin
        rdata     = '0;
        o_tx_push = 1'b0;
        o_rx_pop  = 1'b0;
        case (i_req.addr)
            REG_TXDATA: begin
                rdata[31] = i_tx_full;
                o_tx_push = wr_en;
            end
            REG_RXDATA: begin
                rdata[31]         = i_rx_empty;
                rdata[DATA_W-1:0] = i_rx_data;
                o_rx_pop          = rd_en;     // empty fifo ignores it
            end
            REG_TXCTRL: rdata[2:0] = {o_tx_cfg.par, o_tx_cfg.nstop, o_tx_cfg.ena};
            REG_RXCTRL: rdata[2:0] = {o_rx_cfg.par, o_rx_cfg.nstop, o_rx_cfg.ena};
            REG_STATUS: rdata[1:0] = {i_rx_err.stopbit, i_rx_err.parity};
            REG_SCALER: rdata[30:0] = o_scaler;
            default: rdata = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_tx_cfg <= '0;
            o_rx_cfg <= '0;
            o_scaler <= '0;
        end else if (wr_en) begin
            case (i_req.addr)
                REG_TXCTRL: begin
                    o_tx_cfg.ena   <= i_req.wdata[0];
                    o_tx_cfg.nstop <= i_req.wdata[1];
                    o_tx_cfg.par   <= i_req.wdata[2];
                end
                REG_RXCTRL: begin
                    o_rx_cfg.ena   <= i_req.wdata[0];
                    o_rx_cfg.nstop <= i_req.wdata[1];
                    o_rx_cfg.par   <= i_req.wdata[2];
                end
                REG_SCALER: o_scaler <= i_req.wdata[30:0];
                default: ;
            endcase
        end
    end

    // response lands exactly one cycle after the request
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_resp <= '0;
        end else begin
            o_resp.valid <= i_req.valid;
            o_resp.rdata <= rdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/uart_top.sv ====
//##################################################
// uart_top
// UART core, register block, two byte FIFOs,
// baud generator, transmitter and receiver
//##################################################

`timescale 1ns/1ps
`default_nettype none

module uart_top import uart_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_nrst,
    input  wire uart_req_t i_req,
    input  wire logic      i_rd,
    output uart_resp_t     o_resp,
    output logic           o_td
);

    uart_dir_cfg_t     tx_cfg;
    uart_dir_cfg_t     rx_cfg;
    uart_rx_err_t      rx_err;
    logic [30:0]       scaler;
    logic              tx_push;
    logic [DATA_W-1:0] tx_wdata;
    logic              tx_full;
    logic              tx_empty;
    logic [DATA_W-1:0] tx_head;
    logic              tx_pop;
    logic              tx_busy;
    logic              tx_tick;
    logic              rx_push;
    logic [DATA_W-1:0] rx_data;
    logic              rx_pop;
    logic              rx_empty;
    logic [DATA_W-1:0] rx_head;
    logic              rx_busy;
    logic              rx_tick;

    uart_regs regs_i (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_req      (i_req),
        .i_tx_full  (tx_full),
        .i_rx_empty (rx_empty),
        .i_rx_data  (rx_head),
        .i_rx_err   (rx_err),
        .o_resp     (o_resp),
        .o_tx_cfg   (tx_cfg),
        .o_rx_cfg   (rx_cfg),
        .o_scaler   (scaler),
        .o_tx_push  (tx_push),
        .o_tx_wdata (tx_wdata),
        .o_rx_pop   (rx_pop)
    );

    uart_baud_gen baud_i (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_scaler  (scaler),
        .i_rd      (i_rd),
        .i_tx_busy (tx_busy),
        .i_rx_busy (rx_busy),
        .o_tx_tick (tx_tick),
        .o_rx_tick (rx_tick)
    );

    uart_fifo tx_fifo (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_push  (tx_push),
        .i_wdata (tx_wdata),
        .i_pop   (tx_pop),
        .o_rdata (tx_head),
        .o_full  (tx_full),
        .o_empty (tx_empty)
    );

    uart_fifo rx_fifo (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_push  (rx_push),
        .i_wdata (rx_data),
        .i_pop   (rx_pop),
        .o_rdata (rx_head),
        .o_full  (),            // overflow bytes are dropped in the fifo
        .o_empty (rx_empty)
    );

    uart_tx tx_i (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_tick  (tx_tick),
        .i_cfg   (tx_cfg),
        .i_empty (tx_empty),
        .i_data  (tx_head),
        .o_pop   (tx_pop),
        .o_td    (o_td),
        .o_busy  (tx_busy)
    );

    uart_rx rx_i (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_tick (rx_tick),
        .i_cfg  (rx_cfg),
        .i_rd   (i_rd),
        .o_push (rx_push),
        .o_data (rx_data),
        .o_err  (rx_err),
        .o_busy (rx_busy)
    );

endmodule

`default_nettype wire

// ==== test/tb_uart_tasks.svh ====
//##################################################
// testbench tasks for the UART
// register bus access, serial frame drive and
// polling of the receive FIFO
//##################################################

// response has to follow the request by exactly one cycle
task automatic bus_access(input logic write, input uart_reg_e addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge i_clk);
    req.valid <= 1'b1;
    req.write <= write;
    req.addr  <= addr;
    req.wdata <= wdata;
    @(negedge i_clk);
    check_val("o_resp.valid", {31'd0, resp.valid}, 32'd0);
    @(posedge i_clk);
    req.valid <= 1'b0;
    @(negedge i_clk);
    check_val("o_resp.valid", {31'd0, resp.valid}, 32'd1);
    rdata = resp.rdata;
endtask

task automatic bus_write(input uart_reg_e addr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_access(1'b1, addr, wdata, unused);
endtask

task automatic bus_read(input uart_reg_e addr, output logic [31:0] rdata);
    bus_access(1'b0, addr, 32'd0, rdata);
endtask

// the RXDATA read that finds data also pops it
task automatic recv_byte(output logic [7:0] data);
    logic [31:0] rdata;
    int          polls;
    polls = 0;
    rdata = 32'h8000_0000;
    while (rdata[31] && polls < POLL_MAX) begin
        bus_read(REG_RXDATA, rdata);
        polls++;
    end
    if (rdata[31]) begin
        abort_run("no byte arrived in the RX FIFO");
    end else begin
        data = rdata[7:0];
    end
endtask

// RXDATA has to stay empty for a number of frame times
task automatic expect_rx_empty(input int frames);
    logic [31:0] rdata;
    int          cycles;
    cycles = 0;
    while (cycles < frames * FRAME_CLKS) begin
        bus_read(REG_RXDATA, rdata);
        check_val("RXDATA[31]", {31'd0, rdata[31]}, 32'd1);
        cycles += 2;
    end
endtask

task automatic hold_bit(input logic value);
    tb_rd <= value;
    repeat (2 * SCALER) @(posedge i_clk);
endtask

// start, 8 data lsb first, parity, one stop
task automatic drive_frame(input logic [7:0] data, input logic par_bit,
                           input logic stop_bit);
    @(posedge i_clk);
    hold_bit(1'b1);
    hold_bit(1'b1);     // idle lead-in so the baud counter resyncs
    hold_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
        hold_bit(data[i]);
    end
    hold_bit(par_bit);
    hold_bit(stop_bit);
    hold_bit(1'b1);
endtask

// ==== test/tb_uart.sv ====
//##################################################
// tb_uart
// testbench for the UART core, register bus access,
// loopback and driven frames, FIFO full handling
//##################################################

`timescale 1ns/1ps
`default_nettype none

module tb_uart import uart_pkg::*;;

    localparam int SCALER     = 4;
    localparam int POLL_MAX   = 200;            // RXDATA reads before giving up
    localparam int FRAME_CLKS = 24 * SCALER;    // 12 bit periods incl. idle gap

    logic       i_clk = 1'b0;
    logic       i_nrst;
    uart_req_t  req;
    uart_resp_t resp;
    logic       td;
    logic       tb_rd;      // line driven by the testbench
    logic       loopback;
    logic       rd;

    int err_cnt  = 0;
    int chk_cnt  = 0;
    int test_err = 0;
    int test_num = 0;

    always #10 i_clk = ~i_clk;

    assign rd = loopback ? td : tb_rd;

    uart_top uart_top_i (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_req  (req),
        .i_rd   (rd),
        .o_resp (resp),
        .o_td   (td)
    );

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        chk_cnt++;
        assert (got === exp)
        else begin
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("Regression failed");
        $finish;
    endtask

    task automatic finish_test(input string name);
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, err_cnt - test_err);
        test_err = err_cnt;
    endtask

    `include "tb_uart_tasks.svh"

    initial begin
        logic [31:0] rdata;
        logic [7:0]  rx_byte;
        logic [7:0]  byte_v;
        logic [7:0]  sent [$];
        i_nrst   = 1'b0;
        req      = '0;
        tb_rd    = 1'b1;
        loopback = 1'b0;
        void'($urandom(47));
        repeat (4) @(posedge i_clk);
        i_nrst <= 1'b1;

        @(negedge i_clk);
        check_val("o_td", {31'd0, td}, 32'd1);
        bus_read(REG_TXCTRL, rdata);
        check_val("TXCTRL", rdata, 32'd0);
        bus_read(REG_RXCTRL, rdata);
        check_val("RXCTRL", rdata, 32'd0);
        bus_read(REG_SCALER, rdata);
        check_val("SCALER", rdata, 32'd0);
        bus_read(REG_STATUS, rdata);
        check_val("STATUS", rdata, 32'd0);
        bus_read(REG_TXDATA, rdata);
        check_val("TXDATA", rdata, 32'd0);
        bus_read(REG_RXDATA, rdata);
        check_val("RXDATA[31]", {31'd0, rdata[31]}, 32'd1);
        finish_test("reset state");

        // 8N1 through the loopback
        @(posedge i_clk);
        loopback <= 1'b1;
        bus_write(REG_SCALER, SCALER);
        bus_write(REG_RXCTRL, 32'h1);
        bus_write(REG_TXCTRL, 32'h1);
        byte_v = 8'($urandom);
        bus_write(REG_TXDATA, {24'd0, byte_v});
        recv_byte(rx_byte);
        check_val("RXDATA[7:0]", {24'd0, rx_byte}, {24'd0, byte_v});
        bus_read(REG_STATUS, rdata);
        check_val("STATUS", rdata, 32'd0);
        finish_test("loopback 8N1");

        bus_write(REG_TXCTRL, 32'h7);   // parity, two stop bits
        bus_write(REG_RXCTRL, 32'h7);
        for (int i = 0; i < 8; i++) begin
            byte_v = 8'($urandom);
            sent.push_back(byte_v);
            bus_write(REG_TXDATA, {24'd0, byte_v});
        end
        for (int i = 0; i < 8; i++) begin
            recv_byte(rx_byte);
            check_val("RXDATA[7:0]", {24'd0, rx_byte}, {24'd0, sent[i]});
            bus_read(REG_STATUS, rdata);    // flags of the frame just popped
            check_val("STATUS", rdata, 32'd0);
        end
        expect_rx_empty(1);
        finish_test("loopback 8E2");

        // frames from the testbench line
        @(posedge i_clk);
        loopback <= 1'b0;
        bus_write(REG_RXCTRL, 32'h5);
        byte_v = 8'($urandom);
        drive_frame(byte_v, ~(^byte_v), 1'b1);
        recv_byte(rx_byte);
        check_val("RXDATA[7:0]", {24'd0, rx_byte}, {24'd0, byte_v});
        bus_read(REG_STATUS, rdata);
        check_val("STATUS", rdata, 32'd1);
        byte_v = 8'($urandom);
        drive_frame(byte_v, ^byte_v, 1'b0);
        recv_byte(rx_byte);
        check_val("RXDATA[7:0]", {24'd0, rx_byte}, {24'd0, byte_v});
        bus_read(REG_STATUS, rdata);
        check_val("STATUS", rdata, 32'd2);
        byte_v = 8'($urandom);
        drive_frame(byte_v, ^byte_v, 1'b1);
        recv_byte(rx_byte);
        check_val("RXDATA[7:0]", {24'd0, rx_byte}, {24'd0, byte_v});
        bus_read(REG_STATUS, rdata);
        check_val("STATUS", rdata, 32'd0);
        finish_test("receive errors");

        bus_write(REG_TXCTRL, 32'h0);
        bus_write(REG_RXCTRL, 32'h1);
        @(posedge i_clk);
        loopback <= 1'b1;
        sent.delete();
        for (int i = 0; i < 16; i++) begin
            byte_v = 8'($urandom);
            sent.push_back(byte_v);
            bus_write(REG_TXDATA, {24'd0, byte_v});
            bus_read(REG_TXDATA, rdata);
            check_val("TXDATA[31]", {31'd0, rdata[31]}, {31'd0, i >= 14});
        end
        bus_write(REG_TXCTRL, 32'h1);
        for (int i = 0; i < 15; i++) begin
            recv_byte(rx_byte);
            check_val("RXDATA[7:0]", {24'd0, rx_byte}, {24'd0, sent[i]});
        end
        expect_rx_empty(2);     // 16th byte never went in
        finish_test("tx fifo full");

        $display("%0d tests, %0d checks, %0d errors", test_num, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+test
logic/uart_pkg.sv
logic/uart_baud_gen.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_top.sv
test/tb_uart.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the UART testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_uart -o tb_uart
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_uart)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# pass only when the testbench printed its pass line
if echo "$sim_out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
